// File: bench/store_buffer_properties.sv
/* Protocol assertions on the store buffer ports, bound into every store_buffer instance.
   Input rules of the load/store unit and the stability of a waiting cache request. */
module store_buffer_properties (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          flush_i,
  input logic                          commit_i,
  input logic                          valid_i,
  input logic                          ready_o,
  input logic                          commit_ready_o,
  input logic                          dgnt_i,
  input store_buffer_pkg::dcache_req_t dreq_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // a store is either committed or flushed, never both in one cycle
  a_flush_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flush_i && commit_i)) else $error("flush_i and commit_i high together");

  a_valid_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_i && !ready_o)) else $error("store presented while ready_o is low");

  a_commit_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(commit_i && !commit_ready_o)) else $error("commit while the commit queue is full");

  // an ungranted request keeps its slot and its fields
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dreq_o.req && !dgnt_i) |=> $stable(dreq_o)) else $error("cache request changed before grant");

endmodule

bind store_buffer store_buffer_properties u_properties (
  .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .commit_i(commit_i), .valid_i(valid_i),
  .ready_o(ready_o), .commit_ready_o(commit_ready_o), .dgnt_i(dgnt_i), .dreq_o(dreq_o)
);

// File: bench/tb_store_buffer.sv
/* Directed testbench for the store buffer with a level-driven cache grant model.
   Each test task drives the DUT and checks the cache requests against a model queue. */
`include "store_buffer_defs.svh"

module tb_store_buffer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT_CYCLES = 100;

  logic clk_i, rst_ni, flush_i, stall_st_pending_i, commit_i, valid_i, valid_without_flush_i;
  logic [`SB_PLEN-1:0]    paddr_i;
  logic [`SB_XLEN-1:0]    data_i;
  logic [`SB_BE_W-1:0]    be_i;
  logic [`SB_SIZE_W-1:0]  size_i;
  logic [`SB_OFFSET_HI:0] page_offset_i;
  logic dgnt_i;
  store_buffer_pkg::dcache_req_t dreq_o;
  logic ready_o, commit_ready_o, no_st_pending_o, store_buffer_empty_o, page_offset_matches_o;

  // stores written but not committed, and committed stores still owed to the cache
  store_buffer_pkg::store_entry_t spec_model[$];
  store_buffer_pkg::store_entry_t expected[$];
  int unsigned errors, tests_run, tests_failed;

  store_buffer i_store_buffer (.*);

  always #10 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // drain monitor
  // ------------------------------------------------------------
  // a request taken by the cache has to be the oldest committed store
  always @(negedge clk_i) begin : p_drain_monitor
    store_buffer_pkg::store_entry_t exp;
    if (rst_ni && dreq_o.req && dgnt_i) begin
      if (expected.size() == 0) begin
        $display("cache took a request while no committed store was waiting");
        errors++;
      end else begin
        exp = expected.pop_front();
        if (dreq_o.index !== exp.address[`SB_INDEX_W-1:0] ||
            dreq_o.tag !== exp.address[`SB_INDEX_W+`SB_TAG_W-1:`SB_INDEX_W] ||
            dreq_o.wdata !== exp.data || dreq_o.be !== exp.be || dreq_o.size !== exp.size) begin
          $display("[FAIL] %0t: request %h/%h data %h, expected address %h data %h",
                   $time, dreq_o.tag, dreq_o.index, dreq_o.wdata, exp.address, exp.data);
          errors++;
        end
      end
    end
  end

  function automatic store_buffer_pkg::store_entry_t random_entry();
    store_buffer_pkg::store_entry_t e;
    logic [31:0] r;
    r         = $urandom();
    e.address = $urandom();
    e.data    = $urandom();
    e.be      = r[`SB_BE_W-1:0];
    e.size    = r[`SB_BE_W+`SB_SIZE_W-1:`SB_BE_W];
    return e;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic push_store(input store_buffer_pkg::store_entry_t e);
    @(posedge clk_i);
    valid_i <= 1'b1;
    paddr_i <= e.address;
    data_i  <= e.data;
    be_i    <= e.be;
    size_i  <= e.size;
    @(posedge clk_i);
    valid_i <= 1'b0;
    spec_model.push_back(e);
  endtask

  // the oldest speculative store becomes owed to the cache
  task automatic commit_store();
    @(posedge clk_i);
    commit_i <= 1'b1;
    expected.push_back(spec_model.pop_front());
    @(posedge clk_i);
    commit_i <= 1'b0;
  endtask

  task automatic flush_stores();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    spec_model.delete();
  endtask

  task automatic set_grant(input logic level);
    @(posedge clk_i);
    dgnt_i <= level;
  endtask

  task automatic wait_drained();
    bit done;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT_CYCLES && !done; n++) begin
      @(negedge clk_i);
      done = (expected.size() == 0) && !dreq_o.req;
    end
    if (!done) begin
      $display("timeout while waiting for the committed stores to drain");
      errors++;
    end
  endtask

  task automatic expect_match(input logic level, input string what);
    @(negedge clk_i);
    if (page_offset_matches_o !== level) report_mismatch(what);
  endtask

  task automatic finish_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_order();
    int unsigned err_before;
    err_before = errors;
    set_grant(1'b1);
    for (int i = 0; i < 3; i++) push_store(random_entry());
    for (int i = 0; i < 3; i++) commit_store();
    wait_drained();
    if (!no_st_pending_o || !store_buffer_empty_o) report_mismatch("buffer not empty after drain");
    finish_test("order and content", err_before);
  endtask

  // only the committed store may reach the cache
  task automatic test_flush();
    int unsigned err_before;
    err_before = errors;
    for (int i = 0; i < 3; i++) push_store(random_entry());
    @(negedge clk_i);
    if (store_buffer_empty_o !== 1'b0 || no_st_pending_o !== 1'b1)
      report_mismatch("status wrong with only speculative stores queued");
    commit_store();
    flush_stores();
    // a store written after the flush has to be the next one the cache sees
    push_store(random_entry());
    commit_store();
    wait_drained();
    if (!store_buffer_empty_o) report_mismatch("store_buffer_empty_o low after flush and drain");
    finish_test("flush", err_before);
  endtask

  task automatic test_backpressure();
    int unsigned err_before;
    store_buffer_pkg::dcache_req_t held;
    err_before = errors;
    set_grant(1'b0);
    for (int i = 0; i < 2; i++) push_store(random_entry());
    for (int i = 0; i < 2; i++) commit_store();
    @(negedge clk_i);
    held = dreq_o;
    if (!held.req) report_mismatch("no request with committed stores and no stall");
    if (no_st_pending_o !== 1'b0 || store_buffer_empty_o !== 1'b0)
      report_mismatch("status outputs high with committed stores waiting");
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      if (dreq_o !== held) report_mismatch("head request changed while the grant was low");
    end
    set_grant(1'b1);
    wait_drained();
    // the stall goes up before anything is committed so no request is withdrawn
    set_grant(1'b0);
    @(posedge clk_i);
    stall_st_pending_i <= 1'b1;
    for (int i = 0; i < 2; i++) push_store(random_entry());
    for (int i = 0; i < 2; i++) commit_store();
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_i);
      if (dreq_o.req !== 1'b0) report_mismatch("request raised while draining is stalled");
    end
    @(posedge clk_i);
    stall_st_pending_i <= 1'b0;
    set_grant(1'b1);
    wait_drained();
    finish_test("back-pressure and stall", err_before);
  endtask

  task automatic test_capacity();
    int unsigned err_before;
    err_before = errors;
    set_grant(1'b0);
    for (int i = 0; i < `SB_DEPTH_SPEC; i++) push_store(random_entry());
    @(negedge clk_i);
    if (ready_o !== 1'b0) report_mismatch("ready_o high with a full speculative queue");
    // a commit frees a slot within the same cycle
    @(posedge clk_i);
    commit_i <= 1'b1;
    expected.push_back(spec_model.pop_front());
    @(negedge clk_i);
    if (ready_o !== 1'b1) report_mismatch("ready_o low while commit_i is high");
    @(posedge clk_i);
    commit_i <= 1'b0;
    for (int i = 1; i < `SB_DEPTH_COMMIT; i++) commit_store();
    @(negedge clk_i);
    if (commit_ready_o !== 1'b0) report_mismatch("commit_ready_o high with a full commit queue");
    set_grant(1'b1);
    wait_drained();
    finish_test("capacity", err_before);
  endtask

  task automatic test_alias();
    int unsigned err_before;
    store_buffer_pkg::store_entry_t a, b;
    logic [`SB_PLEN-1:0] c;
    err_before = errors;
    a = random_entry();
    b = random_entry();
    c = $urandom();
    a.address[`SB_OFFSET_HI:`SB_OFFSET_LO] = 9'h010;
    b.address[`SB_OFFSET_HI:`SB_OFFSET_LO] = 9'h0a5;
    c[`SB_OFFSET_HI:`SB_OFFSET_LO]         = 9'h1f3;
    set_grant(1'b0);
    push_store(a);
    commit_store();
    push_store(b);
    // bits below the compared range do not matter
    @(posedge clk_i);
    page_offset_i <= {9'h010, 3'b111};
    expect_match(1'b1, "no match against a committed store");
    @(posedge clk_i);
    page_offset_i <= {9'h0a5, 3'b000};
    expect_match(1'b1, "no match against a speculative store");
    @(posedge clk_i);
    page_offset_i <= {9'h07e, 3'b010};
    expect_match(1'b0, "match for an offset held by no store");
    @(posedge clk_i);
    paddr_i               <= c;
    valid_without_flush_i <= 1'b1;
    page_offset_i         <= c[`SB_OFFSET_HI:0];
    expect_match(1'b1, "no match against the incoming address");
    @(posedge clk_i);
    valid_without_flush_i <= 1'b0;
    expect_match(1'b0, "match on the incoming address without valid_without_flush_i");
    flush_stores();
    set_grant(1'b1);
    wait_drained();
    @(posedge clk_i);
    page_offset_i <= {9'h010, 3'b000};
    expect_match(1'b0, "match after the buffer has emptied");
    @(posedge clk_i);
    page_offset_i <= {9'h0a5, 3'b000};
    expect_match(1'b0, "match against a flushed store");
    finish_test("alias check", err_before);
  endtask

  initial begin : p_main
    void'($urandom(32'h56a2_5850));
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {flush_i, stall_st_pending_i, commit_i, valid_i, valid_without_flush_i, dgnt_i} = '0;
    paddr_i = '0;
    data_i = '0;
    be_i = '0;
    size_i = '0;
    page_offset_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (dreq_o.req || !ready_o || !commit_ready_o || !no_st_pending_o || !store_buffer_empty_o)
      report_mismatch("outputs wrong after reset");
    test_order();
    test_flush();
    test_backpressure();
    test_capacity();
    test_alias();
    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: hdl/page_offset_checker.sv
/* Tells the load path whether a load page offset may alias a buffered or incoming store.
   Purely combinational, evaluated in the same cycle as the load offset. */
`include "store_buffer_defs.svh"

module page_offset_checker #(
  parameter int unsigned SPEC_DEPTH   = 4,
  parameter int unsigned COMMIT_DEPTH = 4
) (
  input  logic [`SB_OFFSET_HI:0]          page_offset_i,
  input  store_buffer_pkg::store_entry_t  spec_entries_i [SPEC_DEPTH],
  input  logic [SPEC_DEPTH-1:0]           spec_valid_i,
  input  store_buffer_pkg::store_entry_t  commit_entries_i [COMMIT_DEPTH],
  input  logic [COMMIT_DEPTH-1:0]         commit_valid_i,
  input  logic [`SB_PLEN-1:0]             incoming_paddr_i,
  input  logic                            incoming_valid_i,
  output logic                            match_o
);

  // the load offset bits that take part in the comparison
  logic [`SB_OFFSET_HI:`SB_OFFSET_LO] load_offset;

  assign load_offset = page_offset_i[`SB_OFFSET_HI:`SB_OFFSET_LO];

  // page offsets are equal in the virtual and the physical address
  // so a match here means the load has to wait for the buffer to drain
  always_comb begin : p_match
    match_o = 1'b0;

    // stores that are already committed and wait for the cache
    for (int unsigned i = 0; i < COMMIT_DEPTH; i++) begin
      if (commit_valid_i[i] &&
          (commit_entries_i[i].address[`SB_OFFSET_HI:`SB_OFFSET_LO] == load_offset)) begin
        match_o = 1'b1;
      end
    end

    // stores that may still be flushed count as well
    for (int unsigned i = 0; i < SPEC_DEPTH; i++) begin
      if (spec_valid_i[i] &&
          (spec_entries_i[i].address[`SB_OFFSET_HI:`SB_OFFSET_LO] == load_offset)) begin
        match_o = 1'b1;
      end
    end

    // the store being presented in this very cycle
    if (incoming_valid_i &&
        (incoming_paddr_i[`SB_OFFSET_HI:`SB_OFFSET_LO] == load_offset)) begin
      match_o = 1'b1;
    end
  end

endmodule

// File: hdl/store_buffer.sv
/* Store buffer of the load/store unit with a speculative and a commit queue.
   Committed stores drain to the data cache over a request/grant pair. */
`include "store_buffer_defs.svh"

module store_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         stall_st_pending_i,
  input  logic                         commit_i,
  input  logic                         valid_i,
  input  logic                         valid_without_flush_i,
  input  logic [`SB_PLEN-1:0]          paddr_i,
  input  logic [`SB_XLEN-1:0]          data_i,
  input  logic [`SB_BE_W-1:0]          be_i,
  input  logic [`SB_SIZE_W-1:0]        size_i,
  input  logic [`SB_OFFSET_HI:0]       page_offset_i,
  input  logic                         dgnt_i,
  output store_buffer_pkg::dcache_req_t dreq_o,
  output logic                         ready_o,
  output logic                         commit_ready_o,
  output logic                         no_st_pending_o,
  output logic                         store_buffer_empty_o,
  output logic                         page_offset_matches_o
);

  store_buffer_pkg::store_entry_t new_entry;
  store_buffer_pkg::store_entry_t spec_head, commit_head;
  store_buffer_pkg::store_entry_t spec_entries [`SB_DEPTH_SPEC];
  store_buffer_pkg::store_entry_t commit_entries [`SB_DEPTH_COMMIT];
  logic [`SB_DEPTH_SPEC-1:0]   spec_valid;
  logic [`SB_DEPTH_COMMIT-1:0] commit_valid;
  logic spec_full, spec_empty;
  logic commit_full, commit_empty, commit_head_valid;
  logic drain_req;

  // the incoming store as one queue entry
  assign new_entry = '{address: paddr_i, data: data_i, be: be_i, size: size_i};

  // ------------------------------------------------------------
  // speculative queue
  // ------------------------------------------------------------
  // a flush throws away every store that has not been committed yet
  store_ring_queue #(
    .DEPTH     (`SB_DEPTH_SPEC),
    .entry_t   (store_buffer_pkg::store_entry_t),
    .CLEARABLE (1'b1)
  ) u_spec_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (valid_i),
    .push_entry_i (new_entry),
    .pop_i        (commit_i),
    .clear_i      (flush_i),
    .head_o       (spec_head),
    .head_valid_o (),
    .entries_o    (spec_entries),
    .valid_o      (spec_valid),
    .full_o       (spec_full),
    .empty_o      (spec_empty)
  );

  // a commit frees a slot in the same cycle so a store may enter a full queue
  assign ready_o = !spec_full || commit_i;

  // ------------------------------------------------------------
  // commit queue and cache port
  // ------------------------------------------------------------
  // commit moves the oldest speculative store over in one cycle
  store_ring_queue #(
    .DEPTH     (`SB_DEPTH_COMMIT),
    .entry_t   (store_buffer_pkg::store_entry_t),
    .CLEARABLE (1'b0)
  ) u_commit_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (commit_i),
    .push_entry_i (spec_head),
    .pop_i        (drain_req && dgnt_i),
    .head_o       (commit_head),
    .head_valid_o (commit_head_valid),
    .entries_o    (commit_entries),
    .valid_o      (commit_valid),
    .full_o       (commit_full),
    .empty_o      (commit_empty)
  );

  // request the head store unless draining is held back
  // the head stays put until the grant so all fields are stable
  assign drain_req = commit_head_valid && !stall_st_pending_i;

  assign dreq_o.req   = drain_req;
  assign dreq_o.index = commit_head.address[`SB_INDEX_W-1:0];
  assign dreq_o.tag   = commit_head.address[`SB_TAG_W+`SB_INDEX_W-1:`SB_INDEX_W];
  assign dreq_o.wdata = commit_head.data;
  assign dreq_o.be    = commit_head.be;
  assign dreq_o.size  = commit_head.size;

  // status towards the load/store unit
  assign commit_ready_o       = !commit_full;
  assign no_st_pending_o      = commit_empty;
  assign store_buffer_empty_o = spec_empty && commit_empty;

  // ------------------------------------------------------------
  // address checker
  // ------------------------------------------------------------
  page_offset_checker #(
    .SPEC_DEPTH   (`SB_DEPTH_SPEC),
    .COMMIT_DEPTH (`SB_DEPTH_COMMIT)
  ) u_offset_checker (
    .page_offset_i    (page_offset_i),
    .spec_entries_i   (spec_entries),
    .spec_valid_i     (spec_valid),
    .commit_entries_i (commit_entries),
    .commit_valid_i   (commit_valid),
    .incoming_paddr_i (paddr_i),
    .incoming_valid_i (valid_without_flush_i),
    .match_o          (page_offset_matches_o)
  );

endmodule

// File: hdl/store_buffer_defs.svh
/* Widths and depths shared by the store buffer RTL and its testbench.
   Include this header wherever one of the macros below is needed. */
`ifndef STORE_BUFFER_DEFS_SVH
`define STORE_BUFFER_DEFS_SVH

// physical address and store data widths
`define SB_PLEN 32
`define SB_XLEN 32
`define SB_BE_W (`SB_XLEN / 8)
`define SB_SIZE_W 2

// number of entries in the speculative and in the commit queue
`define SB_DEPTH_SPEC 4
`define SB_DEPTH_COMMIT 4

// the cache index sits in the low address bits and the tag directly above it
`define SB_INDEX_W 12
`define SB_TAG_W 20

// the alias check compares the page offset at 8-byte granularity
`define SB_OFFSET_HI 11
`define SB_OFFSET_LO 3

`endif

// File: hdl/store_buffer_pkg.sv
/* Types shared by the store buffer queues, its address checker and the cache port.
   Other files refer to them by scoped names. */
`include "store_buffer_defs.svh"

package store_buffer_pkg;

  // one buffered store as it travels from the speculative to the commit queue
  typedef struct packed {
    logic [`SB_PLEN-1:0]   address;
    logic [`SB_XLEN-1:0]   data;
    logic [`SB_BE_W-1:0]   be;
    logic [`SB_SIZE_W-1:0] size;
  } store_entry_t;

  // write request towards the data cache
  // the request is always a write and needs no response, so only the payload is carried
  typedef struct packed {
    logic                  req;
    logic [`SB_INDEX_W-1:0] index;
    logic [`SB_TAG_W-1:0]  tag;
    logic [`SB_XLEN-1:0]   wdata;
    logic [`SB_BE_W-1:0]   be;
    logic [`SB_SIZE_W-1:0] size;
  } dcache_req_t;

endpackage

// File: hdl/store_ring_queue.sv
/* Circular queue of buffered stores with per-entry valid flags and an optional bulk clear.
   Serves as both the speculative queue and the commit queue of the store buffer. */
module store_ring_queue #(
  parameter int unsigned DEPTH     = 4,
  parameter type         entry_t   = logic,
  parameter bit          CLEARABLE = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  entry_t     push_entry_i,
  input  logic       pop_i,
  input  logic       clear_i = 1'b0,
  output entry_t     head_o,
  output logic       head_valid_o,
  output entry_t     entries_o [DEPTH],
  output logic [DEPTH-1:0] valid_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

  // pointers wrap on their own, which needs a power of two depth
  if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("store_ring_queue needs a power of two depth");
  end

  // storage and the per-entry valid flags that the alias check looks at
  entry_t           mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q;

  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count_q;
  logic             do_clear;

  // the clear input only has an effect on the clearable instance
  assign do_clear = CLEARABLE && clear_i;

  // read pointer after this cycle's pop
  // a clear rewinds the write pointer here so that the queue ends up empty
  assign rd_ptr_next = pop_i ? rd_ptr_q + 1'b1 : rd_ptr_q;

  // ------------------------------------------------------------
  // control state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      valid_q  <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_next;
      if (do_clear) begin
        // drop every entry still waiting in the queue
        valid_q  <= '0;
        wr_ptr_q <= rd_ptr_next;
        count_q  <= '0;
      end else begin
        // the pop is applied first so that a push into the same slot wins
        if (pop_i) begin
          valid_q[rd_ptr_q] <= 1'b0;
        end
        if (push_i) begin
          valid_q[wr_ptr_q] <= 1'b1;
          wr_ptr_q          <= wr_ptr_q + 1'b1;
        end
        // occupancy only moves when exactly one of push and pop happens
        if (push_i && !pop_i) begin
          count_q <= count_q + 1'b1;
        end else if (pop_i && !push_i) begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // entry storage
  // ------------------------------------------------------------
  // the payload is only meaningful where the valid flag is set
  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // oldest entry and whether it holds a store
  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = valid_q[rd_ptr_q];

  // whole array goes out for the page offset comparison
  assign entries_o = mem_q;
  assign valid_o   = valid_q;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the store buffer testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=Vtb_store_buffer
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_store_buffer \
    -Mdir "$build_dir" -o "$sim_bin" -f verilog.f; then
  echo "build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF "*** TEST PASSED ***" "$log_file"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

// File: verilog.f
+incdir+hdl
hdl/store_buffer_pkg.sv
hdl/store_ring_queue.sv
hdl/page_offset_checker.sv
hdl/store_buffer.sv
bench/store_buffer_properties.sv
bench/tb_store_buffer.sv
